// File: rtl/uart_params.svh
// UART link parameters
// Host command codes, response tags, frame lengths and default bit period
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// ==============================
// Bit timing
// ==============================
`define UART_CLKS_PER_BIT_DEF 217 // 25 MHz / 115200 baud

// ==============================
// Host commands, also response tags for register reads
// ==============================
`define UART_CMD_RUN      8'h52 // 'R'
`define UART_CMD_STOP     8'h53 // 'S'
`define UART_CMD_MPR_READ 8'h6D // 'm'
`define UART_CMD_ADS_READ 8'h61 // 'a'

// Data tags from the core
`define UART_TAG_MPR_DATA 8'h4D // 'M'
`define UART_TAG_ADS_DATA 8'h41 // 'A'

// Response lengths in bytes, tag included
`define UART_LEN_SHORT 3
`define UART_LEN_LONG  5

`endif

// File: rtl/uart_pkg.sv
// UART link types
// Byte, command and response words, byte counter and controller states

package uart_pkg;

  // ==============================
  // Data widths
  // ==============================
  typedef logic [7:0]  byte_t;      // One serial byte
  typedef logic [15:0] cmd_word_t;  // {code, address}
  typedef logic [39:0] resp_word_t; // Tag in [39:32]
  typedef logic [2:0]  byte_cnt_t;  // Up to 5 bytes per response

  // ==============================
  // Controller FSM
  // ==============================
  typedef enum logic [2:0] {
    IDLE,      // Wait for host byte or response
    RX_ADDR,   // Register read, address byte pending
    TX_DECODE, // Tag to length
    TX_SEND,   // Hand one byte to transmitter
    TX_WAIT    // Byte on the wire
  } ctrl_state_t;

endpackage

// File: rtl/uart_byte_if.sv
// UART byte bus
// Byte strobes between the serial receiver, transmitter and controller
`timescale 1ns/1ps

interface uart_byte_if import uart_pkg::*; ();

  logic  rx_valid; // One cycle per received byte
  byte_t rx_byte;
  logic  tx_start; // One cycle, taken only while tx idle
  byte_t tx_byte;
  logic  tx_done;  // End of stop bit

  // Receiver side
  modport rx_side (output rx_valid, output rx_byte);

  // Transmitter side
  modport tx_side (input tx_start, input tx_byte, output tx_done);

  // Command controller
  modport ctrl (
    input  rx_valid, rx_byte, tx_done,
    output tx_start, tx_byte
  );

endinterface

// File: rtl/uart_rx.sv
// UART receiver, 8N1
// Samples each bit at its middle, LSB first, and pulses rx_valid with the byte
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT_DEF
) (
  input  logic i_CLK,
  input  logic i_RST,
  input  logic i_uart_rxd,
  uart_byte_if.rx_side rx
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t        r_state;
  logic [CNT_W-1:0] r_clk_cnt;  // Cycles within a bit
  logic [2:0]       r_bit_idx;  // Data bit number
  logic             r_rxd_meta;
  logic             r_rxd_sync;
  logic             r_rxd_prev; // For falling edge
  logic             w_fall;
  logic             w_bit_end;

  // ==============================
  // Line synchronizer
  // ==============================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_rxd_meta <= 1'b1; // Idle line is high
      r_rxd_sync <= 1'b1;
      r_rxd_prev <= 1'b1;
    end else begin
      r_rxd_meta <= i_uart_rxd;
      r_rxd_sync <= r_rxd_meta;
      r_rxd_prev <= r_rxd_sync;
    end
  end

  assign w_fall    = r_rxd_prev & ~r_rxd_sync; // Start edge
  assign w_bit_end = (r_clk_cnt == BIT_LAST);

  // ==============================
  // Bit timing FSM
  // ==============================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state     <= RX_IDLE;
      r_clk_cnt   <= '0;
      r_bit_idx   <= '0;
      rx.rx_valid <= 1'b0;
    end else begin
      rx.rx_valid <= 1'b0; // Pulse only
      case (r_state)
        RX_IDLE: begin
          r_clk_cnt <= '0;
          if (w_fall) r_state <= RX_START;
        end
        RX_START: begin
          if (r_clk_cnt == HALF_LAST) begin
            r_clk_cnt <= '0;
            r_bit_idx <= '0;
            // Glitch check at mid start bit
            r_state   <= r_rxd_sync ? RX_IDLE : RX_DATA;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (w_bit_end) begin
            r_clk_cnt <= '0;
            if (r_bit_idx == 3'd7) r_state <= RX_STOP;
            else r_bit_idx <= r_bit_idx + 1'b1;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          // Middle of stop bit, rest is covered by the edge wait in idle
          if (w_bit_end) begin
            rx.rx_valid <= 1'b1;
            r_state     <= RX_IDLE;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        default: r_state <= RX_IDLE;
      endcase
    end
  end

  // Shift in at mid-bit, LSB arrives first
  always_ff @(posedge i_CLK) begin
    if (r_state == RX_DATA && w_bit_end) rx.rx_byte <= {r_rxd_sync, rx.rx_byte[7:1]};
  end

endmodule

// File: rtl/uart_tx.sv
// UART transmitter, 8N1
// Start bit, 8 data bits LSB first, stop bit, then a one-cycle done pulse
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT_DEF
) (
  input  logic i_CLK,
  input  logic i_RST,
  output logic o_uart_txd,
  uart_byte_if.tx_side tx
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t        r_state;
  logic [CNT_W-1:0] r_clk_cnt;
  logic [2:0]       r_bit_idx;
  byte_t            r_data;    // Latched byte
  logic             w_bit_end;

  assign w_bit_end = (r_clk_cnt == BIT_LAST);

  // ==============================
  // Framing FSM
  // ==============================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state    <= TX_IDLE;
      r_clk_cnt  <= '0;
      r_bit_idx  <= '0;
      o_uart_txd <= 1'b1; // Line idles high
      tx.tx_done <= 1'b0;
    end else begin
      tx.tx_done <= 1'b0;
      case (r_state)
        TX_IDLE: begin
          o_uart_txd <= 1'b1;
          r_clk_cnt  <= '0;
          if (tx.tx_start) begin
            o_uart_txd <= 1'b0; // Start bit
            r_state    <= TX_START;
          end
        end
        TX_START: begin
          if (w_bit_end) begin
            r_clk_cnt  <= '0;
            r_bit_idx  <= '0;
            o_uart_txd <= r_data[0];
            r_state    <= TX_DATA;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (w_bit_end) begin
            r_clk_cnt <= '0;
            if (r_bit_idx == 3'd7) begin
              o_uart_txd <= 1'b1; // Stop bit
              r_state    <= TX_STOP;
            end else begin
              r_bit_idx  <= r_bit_idx + 1'b1;
              o_uart_txd <= r_data[r_bit_idx + 3'd1];
            end
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (w_bit_end) begin
            tx.tx_done <= 1'b1; // Back to idle on same edge
            r_state    <= TX_IDLE;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        default: r_state <= TX_IDLE;
      endcase
    end
  end

  // Byte is taken only from idle
  always_ff @(posedge i_CLK) begin
    if (r_state == TX_IDLE && tx.tx_start) r_data <= tx.tx_byte;
  end

endmodule

// File: rtl/uart_cmd_ctrl.sv
// UART command controller
// Decodes host bytes into command words and frames core responses into bytes
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_cmd_ctrl import uart_pkg::*; (
  input  logic        i_CLK,
  input  logic        i_RST,
  input  logic        i_core_busy,
  input  resp_word_t  i_resp_word,
  input  logic        i_resp_valid,
  output logic        o_resp_ready,
  output cmd_word_t   o_cmd_word,
  output logic        o_cmd_valid,
  uart_byte_if.ctrl   bus
);

  ctrl_state_t r_state;
  resp_word_t  r_shift;    // Response, top byte goes out next
  byte_cnt_t   r_byte_cnt; // Bytes handed to tx
  byte_cnt_t   r_byte_len; // Bytes this response

  logic      w_idle;
  logic      w_rx_cmd;   // R or S, one-byte command
  logic      w_rx_read;  // m or a, address follows
  logic      w_rx_addr;  // Address byte in
  logic      w_accept;   // Response taken
  logic      w_shift;    // Byte sent, move to next
  byte_cnt_t w_tag_len;

  // ==============================
  // Decode
  // ==============================
  assign w_idle = (r_state == IDLE);

  // Busy core only listens for stop
  assign w_rx_cmd = w_idle && bus.rx_valid &&
                    (((bus.rx_byte == `UART_CMD_RUN) && !i_core_busy) ||
                     ((bus.rx_byte == `UART_CMD_STOP) && i_core_busy));

  assign w_rx_read = w_idle && bus.rx_valid && !i_core_busy &&
                     ((bus.rx_byte == `UART_CMD_MPR_READ) ||
                      (bus.rx_byte == `UART_CMD_ADS_READ));

  assign w_rx_addr = (r_state == RX_ADDR) && bus.rx_valid;

  // Host byte wins over a waiting response
  assign w_accept = w_idle && !bus.rx_valid && i_resp_valid && o_resp_ready;

  assign w_shift = (r_state == TX_WAIT) && bus.tx_done;

  // Length from tag, zero drops the word
  always_comb begin
    case (r_shift[39:32])
      `UART_TAG_ADS_DATA: w_tag_len = byte_cnt_t'(`UART_LEN_LONG);
      `UART_TAG_MPR_DATA,
      `UART_CMD_MPR_READ,
      `UART_CMD_ADS_READ: w_tag_len = byte_cnt_t'(`UART_LEN_SHORT);
      default:            w_tag_len = '0;
    endcase
  end

  // ==============================
  // Control FSM
  // ==============================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state      <= IDLE;
      r_byte_cnt   <= '0;
      r_byte_len   <= '0;
      o_resp_ready <= 1'b0;
      o_cmd_valid  <= 1'b0;
      bus.tx_start <= 1'b0;
    end else begin
      o_cmd_valid  <= w_rx_cmd || w_rx_addr; // Cycle after rx_valid
      bus.tx_start <= 1'b0;
      case (r_state)
        IDLE: begin
          o_resp_ready <= 1'b1;
          if (w_rx_read) begin
            o_resp_ready <= 1'b0;
            r_state      <= RX_ADDR;
          end else if (w_accept) begin
            o_resp_ready <= 1'b0; // Low from next cycle
            r_state      <= TX_DECODE;
          end
        end
        RX_ADDR: begin
          if (bus.rx_valid) begin
            o_resp_ready <= 1'b1;
            r_state      <= IDLE;
          end
        end
        TX_DECODE: begin
          r_byte_cnt <= '0;
          r_byte_len <= w_tag_len;
          if (w_tag_len == '0) begin
            // Unknown tag, nothing on the wire
            o_resp_ready <= 1'b1;
            r_state      <= IDLE;
          end else begin
            r_state <= TX_SEND;
          end
        end
        TX_SEND: begin
          bus.tx_start <= 1'b1;
          r_byte_cnt   <= r_byte_cnt + 1'b1;
          r_state      <= TX_WAIT;
        end
        TX_WAIT: begin
          if (w_shift) begin
            if (r_byte_cnt == r_byte_len) begin
              o_resp_ready <= 1'b1; // Cycle after last tx_done
              r_state      <= IDLE;
            end else begin
              r_state <= TX_SEND;
            end
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  // ==============================
  // Data path
  // ==============================
  always_ff @(posedge i_CLK) begin
    // Code first, address fills the low byte later
    if (w_rx_cmd || w_rx_read) o_cmd_word <= {bus.rx_byte, 8'h00};
    else if (w_rx_addr) o_cmd_word[7:0] <= bus.rx_byte;

    if (w_accept) r_shift <= i_resp_word;
    else if (w_shift) r_shift <= r_shift << 8; // MSB first

    if (r_state == TX_SEND) bus.tx_byte <= r_shift[39:32];
  end

endmodule

// File: rtl/uart_link_top.sv
// UART link top level
// Receiver, command controller and transmitter joined by the byte bus
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link_top import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT_DEF
) (
  input  logic       i_CLK,
  input  logic       i_RST,
  // Core response side
  input  resp_word_t i_resp_word,
  input  logic       i_resp_valid,
  output logic       o_resp_ready,
  // Core command side
  output cmd_word_t  o_cmd_word,
  output logic       o_cmd_valid,
  input  logic       i_core_busy,
  // Serial line to host
  input  logic       i_uart_rxd,
  output logic       o_uart_txd
);

  uart_byte_if u_bus ();

  // Host to controller
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .i_CLK      (i_CLK),
    .i_RST      (i_RST),
    .i_uart_rxd (i_uart_rxd),
    .rx         (u_bus.rx_side)
  );

  uart_cmd_ctrl u_ctrl (
    .i_CLK        (i_CLK),
    .i_RST        (i_RST),
    .i_core_busy  (i_core_busy),
    .i_resp_word  (i_resp_word),
    .i_resp_valid (i_resp_valid),
    .o_resp_ready (o_resp_ready),
    .o_cmd_word   (o_cmd_word),
    .o_cmd_valid  (o_cmd_valid),
    .bus          (u_bus.ctrl)
  );

  // Controller to host
  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .i_CLK      (i_CLK),
    .i_RST      (i_RST),
    .o_uart_txd (o_uart_txd),
    .tx         (u_bus.tx_side)
  );

endmodule

// File: verification/uart_link_chk.sv
// UART link protocol checker
// Concurrent assertions on command strobe, response handshake and serial line
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link_chk import uart_pkg::*; (
  input logic      i_CLK,
  input logic      i_RST,
  input logic      i_resp_valid,
  input logic      o_resp_ready,
  input cmd_word_t o_cmd_word,
  input logic      o_cmd_valid,
  input logic      i_core_busy,
  input logic      i_rx_valid,   // Received byte pending in controller
  input logic      o_uart_txd
);

  int unsigned fail_cnt = 0; // Failed assertions so far

  // Command strobe is a single pulse
  a_cmd_pulse : assert property (@(posedge i_CLK) disable iff (i_RST)
    o_cmd_valid |=> !o_cmd_valid)
    else begin
      fail_cnt++;
      $error("o_cmd_valid longer than one cycle");
    end

  // Ready only in idle where the line rests high
  a_txd_idle : assert property (@(posedge i_CLK) disable iff (i_RST)
    o_resp_ready |-> o_uart_txd)
    else begin
      fail_cnt++;
      $error("o_uart_txd low while o_resp_ready high");
    end

  // Response accepted with no byte pending
  a_ready_fall : assert property (@(posedge i_CLK) disable iff (i_RST)
    (o_resp_ready && i_resp_valid && !i_rx_valid) |=> !o_resp_ready)
    else begin
      fail_cnt++;
      $error("o_resp_ready still high after response accepted");
    end

  // Busy core takes stop only
  a_busy_stop : assert property (@(posedge i_CLK) disable iff (i_RST)
    (o_cmd_valid && i_core_busy) |-> (o_cmd_word[15:8] == `UART_CMD_STOP))
    else begin
      fail_cnt++;
      $error("command other than stop issued while core busy");
    end

endmodule

bind uart_link_top uart_link_chk u_chk (
  .i_CLK        (i_CLK),
  .i_RST        (i_RST),
  .i_resp_valid (i_resp_valid),
  .o_resp_ready (o_resp_ready),
  .o_cmd_word   (o_cmd_word),
  .o_cmd_valid  (o_cmd_valid),
  .i_core_busy  (i_core_busy),
  .i_rx_valid   (u_bus.rx_valid),
  .o_uart_txd   (o_uart_txd)
);

// File: verification/uart_link_tb.sv
// UART link testbench
// Host serial model, core stub and self-checks around the link
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link_tb import uart_pkg::*; ();

  localparam int BIT_CLKS   = 8;
  localparam int MAX_CYCLES = 6000; // About twice the full sequence

  logic       i_CLK;
  logic       i_RST;
  resp_word_t i_resp_word;
  logic       i_resp_valid;
  logic       o_resp_ready;
  cmd_word_t  o_cmd_word;
  logic       o_cmd_valid;
  logic       i_core_busy;
  logic       i_uart_rxd;
  logic       o_uart_txd;

  int        seed = 21;
  int        cycle_cnt = 0;
  cmd_word_t cmd_q[$];     // Words seen on o_cmd_valid
  logic      ready_at_cmd; // o_resp_ready beside last command
  byte_t     host_rx_q[$]; // Bytes decoded from o_uart_txd

  uart_link_top #(.CLKS_PER_BIT(BIT_CLKS)) UUT (
    .i_CLK        (i_CLK),
    .i_RST        (i_RST),
    .i_resp_word  (i_resp_word),
    .i_resp_valid (i_resp_valid),
    .o_resp_ready (o_resp_ready),
    .o_cmd_word   (o_cmd_word),
    .o_cmd_valid  (o_cmd_valid),
    .i_core_busy  (i_core_busy),
    .i_uart_rxd   (i_uart_rxd),
    .o_uart_txd   (o_uart_txd)
  );

  always #10 i_CLK = ~i_CLK; // 20 ns

  // ==============================
  // Checks and run limit
  // ==============================
  task automatic stop_on_error();
    $display("Something failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [39:0] exp, input logic [39:0] act);
    assert (act === exp) else begin
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_event(input logic ok, input string what);
    assert (ok) else begin
      $display("Error at %0t: %s", $time, what);
      stop_on_error();
    end
  endtask

  always @(posedge i_CLK) begin
    cycle_cnt++;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: no result after %0d cycles", MAX_CYCLES);
      stop_on_error();
    end
  end

  // Protocol checker status
  always @(negedge i_CLK) begin
    if (UUT.u_chk.fail_cnt != 0) begin
      $display("Error at %0t: protocol assertion in the bound checker failed", $time);
      stop_on_error();
    end
  end

  // Bytes sent for each tag and none for unknown tags
  function automatic int resp_len(input byte_t tag);
    if (tag == `UART_TAG_ADS_DATA) return `UART_LEN_LONG;
    if (tag == `UART_TAG_MPR_DATA || tag == `UART_CMD_MPR_READ ||
        tag == `UART_CMD_ADS_READ) return `UART_LEN_SHORT;
    return 0;
  endfunction

  // ==============================
  // Host and core models
  // ==============================
  task automatic next_cycle();
    @(posedge i_CLK);
    #2; // Drive point after the edge
  endtask

  task automatic send_host_byte(input byte_t b);
    int i;
    i_uart_rxd = 1'b0; // Start bit
    repeat (BIT_CLKS) next_cycle();
    for (i = 0; i < 8; i++) begin
      i_uart_rxd = b[i]; // LSB first
      repeat (BIT_CLKS) next_cycle();
    end
    i_uart_rxd = 1'b1;
    repeat (BIT_CLKS + 4) next_cycle(); // Stop bit plus gap
  endtask

  // Host receiver sampling near mid-bit
  initial begin : host_rx
    byte_t b;
    int    i;
    @(negedge i_RST);
    forever begin
      @(negedge o_uart_txd);
      repeat (BIT_CLKS / 2) @(negedge i_CLK);
      check_value("o_uart_txd start bit", 40'(0), 40'(o_uart_txd));
      for (i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge i_CLK);
        b[i] = o_uart_txd;
      end
      repeat (BIT_CLKS) @(negedge i_CLK);
      check_value("o_uart_txd stop bit", 40'(1), 40'(o_uart_txd));
      host_rx_q.push_back(b);
    end
  end

  // Command monitor
  always @(negedge i_CLK) begin
    if (o_cmd_valid) begin
      cmd_q.push_back(o_cmd_word);
      ready_at_cmd = o_resp_ready;
    end
  end

  task automatic wait_ready(input logic level);
    while (o_resp_ready !== level) next_cycle();
  endtask

  task automatic expect_cmd(input cmd_word_t exp);
    while (cmd_q.size() == 0) next_cycle();
    check_event(cmd_q.size() == 1, "more than one command word reported");
    check_value("o_cmd_word", 40'(exp), 40'(cmd_q.pop_front()));
  endtask

  task automatic expect_no_cmd();
    repeat (2) next_cycle();
    check_event(cmd_q.size() == 0, "o_cmd_valid pulsed for a byte that should be ignored");
  endtask

  task automatic expect_resp(input resp_word_t w);
    int i;
    int n;
    n = resp_len(w[39:32]);
    wait_ready(1'b1); // Back after last byte
    check_value("serial byte count", 40'(n), 40'(host_rx_q.size()));
    for (i = 0; i < n; i++)
      check_value("o_uart_txd byte", 40'(w[39 - 8*i -: 8]), 40'(host_rx_q[i]));
  endtask

  task automatic send_resp(input resp_word_t w);
    host_rx_q.delete();
    i_resp_word  = w;
    i_resp_valid = 1'b1;
    wait_ready(1'b0); // Taken
    i_resp_valid = 1'b0;
    expect_resp(w);
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin : stimulus
    resp_word_t word;
    byte_t      addr;
    i_CLK        = 1'b0;
    i_RST        = 1'b1;
    i_resp_word  = '0;
    i_resp_valid = 1'b0;
    i_core_busy  = 1'b0;
    i_uart_rxd   = 1'b1; // Line idle
    repeat (2) @(posedge i_CLK);
    #2;
    i_RST = 1'b0;

    // Ready after reset and a run command
    wait_ready(1'b1);
    check_value("o_uart_txd", 40'(1), 40'(o_uart_txd));
    send_host_byte(`UART_CMD_RUN);
    expect_cmd({`UART_CMD_RUN, 8'h00});

    // Register reads with random address
    addr = byte_t'($random(seed));
    send_host_byte(`UART_CMD_MPR_READ);
    send_host_byte(addr);
    expect_cmd({`UART_CMD_MPR_READ, addr});
    addr = byte_t'($random(seed));
    send_host_byte(`UART_CMD_ADS_READ);
    send_host_byte(addr);
    expect_cmd({`UART_CMD_ADS_READ, addr});

    // Busy core lets only stop through
    i_core_busy = 1'b1;
    send_host_byte(`UART_CMD_RUN);
    send_host_byte(`UART_CMD_MPR_READ);
    expect_no_cmd();
    send_host_byte(`UART_CMD_STOP);
    expect_cmd({`UART_CMD_STOP, 8'h00});
    i_core_busy = 1'b0;

    // Long, short and dropped responses
    send_resp({`UART_TAG_ADS_DATA, 32'($random(seed))});
    send_resp({`UART_TAG_MPR_DATA, 32'($random(seed))});
    send_resp({`UART_CMD_MPR_READ, 32'($random(seed))});
    send_resp({`UART_CMD_ADS_READ, 32'($random(seed))});
    send_resp({8'h5A, 32'($random(seed))}); // 'Z'

    // Byte and response in the same idle cycle
    word = {`UART_TAG_MPR_DATA, 32'($random(seed))};
    host_rx_q.delete();
    i_resp_word = word;
    fork
      send_host_byte(`UART_CMD_RUN);
      begin
        while (UUT.u_bus.rx_valid !== 1'b1) next_cycle();
        i_resp_valid = 1'b1;
      end
    join
    expect_cmd({`UART_CMD_RUN, 8'h00});
    check_event(ready_at_cmd, "response taken before the command was reported");
    i_resp_valid = 1'b0;
    expect_resp(word);

    repeat (4) next_cycle();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_byte_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_link_top.sv
verification/uart_link_chk.sv
verification/uart_link_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the UART link testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module uart_link_tb -f compile.f -o Vuart_link_tb

./obj_dir/Vuart_link_tb 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported an error"
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
